/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_inout_ports
FILELIST = inout_ports.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/router_cfg.svh */
`ifndef ROUTER_CFG_SVH
`define ROUTER_CFG_SVH

// router ports: local, east, north, west, south
`define ROUTER_P 5

// virtual channels per port
`define ROUTER_V 2

// flit slots per downstream VC, also the credit count out of reset
`define ROUTER_B 4

`endif

/* inout_ports.f */
+incdir+include
rtl/noc_geom_pkg.sv
rtl/vc_state_pkg.sv
rtl/ivc_assign_table.sv
rtl/ovc_credit_counter.sv
rtl/vc_request_mask.sv
rtl/inout_ports.sv
test/tb_clock_gen.sv
test/tb_inout_ports.sv

/* rtl/inout_ports.sv */
`timescale 1ns/10ps
`default_nettype none

module inout_ports (
    input  wire                                clk,
    input  wire                                reset,

    // from the VC and switch allocators
    input  wire noc_geom_pkg::pv_vec_t         ivc_request,
    input  wire noc_geom_pkg::pv_vec_t         flit_is_tail,
    input  wire noc_geom_pkg::pv_vec_t         ivc_ovc_grant,
    input  wire noc_geom_pkg::pv_vec_t         ivc_sw_grant,
    input  wire noc_geom_pkg::dest_port_arr_t  dest_port,
    input  wire noc_geom_pkg::vc_mask_arr_t    candidate_ovc,
    input  wire noc_geom_pkg::vc_mask_arr_t    granted_ovc,

    // credits from the downstream routers
    input  wire noc_geom_pkg::pv_vec_t         credit_in,

    output wire noc_geom_pkg::vc_mask_arr_t    masked_ovc_request,
    output wire noc_geom_pkg::pv_vec_t         ovc_is_assigned,
    output wire noc_geom_pkg::pv_vec_t         assigned_ovc_not_full,
    output wire noc_geom_pkg::pv_vec_t         ovc_available,
    output wire noc_geom_pkg::pv_vec_t         credit_out
);

    noc_geom_pkg::vc_mask_arr_t assigned_ovc;

    ivc_assign_table i_ivc_assign_table (
        .clk             (clk),
        .reset           (reset),
        .ivc_ovc_grant   (ivc_ovc_grant),
        .ivc_sw_grant    (ivc_sw_grant),
        .flit_is_tail    (flit_is_tail),
        .granted_ovc     (granted_ovc),
        .ovc_is_assigned (ovc_is_assigned),
        .credit_out      (credit_out),
        .assigned_ovc    (assigned_ovc)
    );

    ovc_credit_counter i_ovc_credit_counter (
        .clk                   (clk),
        .reset                 (reset),
        .ivc_ovc_grant         (ivc_ovc_grant),
        .ivc_sw_grant          (ivc_sw_grant),
        .flit_is_tail          (flit_is_tail),
        .credit_in             (credit_in),
        .ovc_is_assigned       (ovc_is_assigned),
        .granted_ovc           (granted_ovc),
        .assigned_ovc          (assigned_ovc),
        .dest_port             (dest_port),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

    // combinational path to the VC allocator
    vc_request_mask i_vc_request_mask (
        .ivc_request        (ivc_request),
        .ovc_is_assigned    (ovc_is_assigned),
        .ovc_available      (ovc_available),
        .candidate_ovc      (candidate_ovc),
        .dest_port          (dest_port),
        .masked_ovc_request (masked_ovc_request)
    );

endmodule

`default_nettype wire

/* rtl/ivc_assign_table.sv */
`timescale 1ns/10ps
`default_nettype none

module ivc_assign_table (
    input  wire                              clk,
    input  wire                              reset,
    input  wire noc_geom_pkg::pv_vec_t       ivc_ovc_grant,
    input  wire noc_geom_pkg::pv_vec_t       ivc_sw_grant,
    input  wire noc_geom_pkg::pv_vec_t       flit_is_tail,
    input  wire noc_geom_pkg::vc_mask_arr_t  granted_ovc,
    output noc_geom_pkg::pv_vec_t            ovc_is_assigned,
    output noc_geom_pkg::pv_vec_t            credit_out,
    output noc_geom_pkg::vc_mask_arr_t       assigned_ovc
);

    localparam int PV = $bits(noc_geom_pkg::pv_vec_t);

    vc_state_pkg::ivc_state_e ivc_state [PV];

    // tail flit leaving through the switch ends the packet
    noc_geom_pkg::pv_vec_t release_ivc;

    assign release_ivc = ivc_sw_grant & flit_is_tail;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < PV; i++) begin
                ivc_state[i] <= vc_state_pkg::IVC_IDLE;
            end
            assigned_ovc <= '0;
            credit_out   <= '0;
        end else begin
            for (int i = 0; i < PV; i++) begin
                // release beats a new grant in the same cycle
                if (release_ivc[i]) begin
                    ivc_state[i] <= vc_state_pkg::IVC_IDLE;
                end else if (ivc_ovc_grant[i]) begin
                    ivc_state[i] <= vc_state_pkg::IVC_ASSIGNED;
                end

                if (ivc_ovc_grant[i]) begin
                    assigned_ovc[i] <= granted_ovc[i];
                end
            end

            // every flit that leaves frees one upstream slot
            credit_out <= ivc_sw_grant;
        end
    end

    always_comb begin
        for (int i = 0; i < PV; i++) begin
            ovc_is_assigned[i] = (ivc_state[i] == vc_state_pkg::IVC_ASSIGNED);
        end
    end

endmodule

`default_nettype wire

/* rtl/noc_geom_pkg.sv */
`default_nettype none

`include "router_cfg.svh"

package noc_geom_pkg;

    // one bit per VC, port-major: index = port * V + vc
    typedef logic [`ROUTER_P*`ROUTER_V-1:0] pv_vec_t;

    // one-hot VC within a single port
    typedef logic [`ROUTER_V-1:0] vc_mask_t;

    // a VC mask per input VC
    typedef vc_mask_t [`ROUTER_P*`ROUTER_V-1:0] vc_mask_arr_t;

    // one-hot over the P-1 ports other than the input's own port
    typedef logic [`ROUTER_P-2:0] dest_port_t;

    // a destination per input VC
    typedef dest_port_t [`ROUTER_P*`ROUTER_V-1:0] dest_port_arr_t;

    // holds 0 .. ROUTER_B
    typedef logic [$clog2(`ROUTER_B+1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

/* rtl/ovc_credit_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "router_cfg.svh"

module ovc_credit_counter (
    input  wire                                clk,
    input  wire                                reset,
    input  wire noc_geom_pkg::pv_vec_t         ivc_ovc_grant,
    input  wire noc_geom_pkg::pv_vec_t         ivc_sw_grant,
    input  wire noc_geom_pkg::pv_vec_t         flit_is_tail,
    input  wire noc_geom_pkg::pv_vec_t         credit_in,
    input  wire noc_geom_pkg::pv_vec_t         ovc_is_assigned,
    input  wire noc_geom_pkg::vc_mask_arr_t    granted_ovc,
    input  wire noc_geom_pkg::vc_mask_arr_t    assigned_ovc,
    input  wire noc_geom_pkg::dest_port_arr_t  dest_port,
    output noc_geom_pkg::pv_vec_t              ovc_available,
    output noc_geom_pkg::pv_vec_t              assigned_ovc_not_full
);

    localparam int P  = `ROUTER_P;
    localparam int V  = `ROUTER_V;
    localparam int PV = $bits(noc_geom_pkg::pv_vec_t);

    // per input VC, the output VC it points at as a PV-wide one-hot
    noc_geom_pkg::pv_vec_t grant_target  [PV];
    noc_geom_pkg::pv_vec_t assign_target [PV];

    noc_geom_pkg::pv_vec_t ovc_alloc;
    noc_geom_pkg::pv_vec_t ovc_flit;
    noc_geom_pkg::pv_vec_t ovc_tail;
    noc_geom_pkg::pv_vec_t cnt_nonzero;

    vc_state_pkg::ovc_state_e  ovc_state  [PV];
    noc_geom_pkg::credit_cnt_t credit_cnt [PV];

    // dest bit j skips over the input's own port
    always_comb begin
        int op;
        for (int i = 0; i < PV; i++) begin
            grant_target[i]  = '0;
            assign_target[i] = '0;
            for (int j = 0; j < P - 1; j++) begin
                op = (j < i / V) ? j : j + 1;
                if (dest_port[i][j]) begin
                    grant_target[i][op*V +: V]  = granted_ovc[i];
                    assign_target[i][op*V +: V] = assigned_ovc[i];
                end
            end
        end
    end

    always_comb begin
        ovc_alloc = '0;
        ovc_flit  = '0;
        ovc_tail  = '0;
        for (int i = 0; i < PV; i++) begin
            if (ivc_ovc_grant[i]) begin
                ovc_alloc = ovc_alloc | grant_target[i];
            end
            if (ivc_sw_grant[i]) begin
                ovc_flit = ovc_flit | assign_target[i];
                if (flit_is_tail[i]) begin
                    ovc_tail = ovc_tail | assign_target[i];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int o = 0; o < PV; o++) begin
                ovc_state[o]  <= vc_state_pkg::OVC_FREE;
                credit_cnt[o] <= noc_geom_pkg::credit_cnt_t'(`ROUTER_B);
            end
        end else begin
            for (int o = 0; o < PV; o++) begin
                // packet end frees the VC even if a grant lands on it
                if (ovc_tail[o]) begin
                    ovc_state[o] <= vc_state_pkg::OVC_FREE;
                end else if (ovc_alloc[o]) begin
                    ovc_state[o] <= vc_state_pkg::OVC_BUSY;
                end

                case ({ovc_flit[o], credit_in[o]})
                    2'b10:   credit_cnt[o] <= credit_cnt[o] - 1'b1;
                    2'b01:   credit_cnt[o] <= credit_cnt[o] + 1'b1;
                    default: credit_cnt[o] <= credit_cnt[o];
                endcase
            end
        end
    end

    always_comb begin
        for (int o = 0; o < PV; o++) begin
            ovc_available[o] = (ovc_state[o] == vc_state_pkg::OVC_FREE);
            cnt_nonzero[o]   = (credit_cnt[o] != '0);
        end
        for (int i = 0; i < PV; i++) begin
            assigned_ovc_not_full[i] = ovc_is_assigned[i] &
                                       (|(assign_target[i] & cnt_nonzero));
        end
    end

endmodule

`default_nettype wire

/* rtl/vc_request_mask.sv */
`timescale 1ns/10ps
`default_nettype none

`include "router_cfg.svh"

module vc_request_mask (
    input  wire noc_geom_pkg::pv_vec_t         ivc_request,
    input  wire noc_geom_pkg::pv_vec_t         ovc_is_assigned,
    input  wire noc_geom_pkg::pv_vec_t         ovc_available,
    input  wire noc_geom_pkg::vc_mask_arr_t    candidate_ovc,
    input  wire noc_geom_pkg::dest_port_arr_t  dest_port,
    output noc_geom_pkg::vc_mask_arr_t         masked_ovc_request
);

    localparam int P  = `ROUTER_P;
    localparam int V  = `ROUTER_V;
    localparam int PV = $bits(noc_geom_pkg::pv_vec_t);

    // availability seen from each input port, own port cut out
    logic [(P-1)*V-1:0] avail_other [P];

    genvar ip;
    generate
        for (ip = 0; ip < P; ip++) begin : g_port
            if (ip == 0) begin : g_first
                assign avail_other[ip] = ovc_available[PV-1:V];
            end else if (ip == P - 1) begin : g_last
                assign avail_other[ip] = ovc_available[PV-V-1:0];
            end else begin : g_mid
                assign avail_other[ip] = {ovc_available[PV-1:(ip+1)*V],
                                          ovc_available[ip*V-1:0]};
            end
        end
    endgenerate

    always_comb begin
        noc_geom_pkg::vc_mask_t avb;
        for (int i = 0; i < PV; i++) begin
            // one-hot mux over the destination port's VCs
            avb = '0;
            for (int j = 0; j < P - 1; j++) begin
                if (dest_port[i][j]) begin
                    avb = avb | avail_other[i / V][j*V +: V];
                end
            end

            // only unassigned VCs ask for an output VC
            if (ivc_request[i] && !ovc_is_assigned[i]) begin
                masked_ovc_request[i] = candidate_ovc[i] & avb;
            end else begin
                masked_ovc_request[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/vc_state_pkg.sv */
`default_nettype none

package vc_state_pkg;

    // input VC: holds an output VC or not
    typedef enum logic {
        IVC_IDLE,
        IVC_ASSIGNED
    } ivc_state_e;

    // output VC: owned by a packet or not
    typedef enum logic {
        OVC_FREE,
        OVC_BUSY
    } ovc_state_e;

endpackage

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, away from the sampling point
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* test/tb_inout_ports.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_inout_ports;

    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 2 + 20;

    typedef struct packed {
        noc_geom_pkg::pv_vec_t         req;
        noc_geom_pkg::pv_vec_t         tail;
        noc_geom_pkg::pv_vec_t         ovc_gnt;
        noc_geom_pkg::pv_vec_t         sw_gnt;
        noc_geom_pkg::pv_vec_t         cred;
        noc_geom_pkg::dest_port_arr_t  dest;
        noc_geom_pkg::vc_mask_arr_t    cand;
        noc_geom_pkg::vc_mask_arr_t    gnt_ovc;
        noc_geom_pkg::vc_mask_arr_t    exp_masked;
        noc_geom_pkg::pv_vec_t         exp_assigned;
        noc_geom_pkg::pv_vec_t         exp_avail;
        noc_geom_pkg::pv_vec_t         exp_not_full;
        noc_geom_pkg::pv_vec_t         exp_credit;
    } row_t;

    row_t rows [NUM_ROWS];
    int   row_count;
    int   error_count;
    int   check_count;
    int   cycle_count;

    noc_geom_pkg::dest_port_arr_t  east_dest;

    logic                          clk;
    logic                          reset;
    noc_geom_pkg::pv_vec_t         ivc_request;
    noc_geom_pkg::pv_vec_t         flit_is_tail;
    noc_geom_pkg::pv_vec_t         ivc_ovc_grant;
    noc_geom_pkg::pv_vec_t         ivc_sw_grant;
    noc_geom_pkg::pv_vec_t         credit_in;
    noc_geom_pkg::dest_port_arr_t  dest_port;
    noc_geom_pkg::vc_mask_arr_t    candidate_ovc;
    noc_geom_pkg::vc_mask_arr_t    granted_ovc;
    noc_geom_pkg::vc_mask_arr_t    masked_ovc_request;
    noc_geom_pkg::pv_vec_t         ovc_is_assigned;
    noc_geom_pkg::pv_vec_t         assigned_ovc_not_full;
    noc_geom_pkg::pv_vec_t         ovc_available;
    noc_geom_pkg::pv_vec_t         credit_out;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    inout_ports i_inout_ports (
        .clk                   (clk),
        .reset                 (reset),
        .ivc_request           (ivc_request),
        .flit_is_tail          (flit_is_tail),
        .ivc_ovc_grant         (ivc_ovc_grant),
        .ivc_sw_grant          (ivc_sw_grant),
        .dest_port             (dest_port),
        .candidate_ovc         (candidate_ovc),
        .granted_ovc           (granted_ovc),
        .credit_in             (credit_in),
        .masked_ovc_request    (masked_ovc_request),
        .ovc_is_assigned       (ovc_is_assigned),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .ovc_available         (ovc_available),
        .credit_out            (credit_out)
    );

    function automatic noc_geom_pkg::pv_vec_t one_bit(input int idx);
        noc_geom_pkg::pv_vec_t v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    function automatic noc_geom_pkg::vc_mask_arr_t vc_at(input int idx,
                                                          input noc_geom_pkg::vc_mask_t m);
        noc_geom_pkg::vc_mask_arr_t v;
        v = '0;
        v[idx] = m;
        return v;
    endfunction

    task automatic compare(input int row, input string name,
                           input logic [31:0] got, input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED row %0d %s: got 0x%h, expected 0x%h",
                     row, name, got, expected);
        end
    endtask

    task automatic add_row(
        input noc_geom_pkg::pv_vec_t      req, tail, ovc_gnt, sw_gnt, cred,
        input noc_geom_pkg::vc_mask_arr_t cand, gnt_ovc, exp_masked,
        input noc_geom_pkg::pv_vec_t      exp_assigned, exp_avail, exp_not_full, exp_credit
    );
        if (row_count < NUM_ROWS) begin
            rows[row_count] = '{req, tail, ovc_gnt, sw_gnt, cred, east_dest, cand, gnt_ovc,
                                exp_masked, exp_assigned, exp_avail, exp_not_full,
                                exp_credit};
        end
        row_count++;
    endtask

    task automatic apply_row(input row_t r);
        ivc_request   = r.req;
        flit_is_tail  = r.tail;
        ivc_ovc_grant = r.ovc_gnt;
        ivc_sw_grant  = r.sw_gnt;
        credit_in     = r.cred;
        dest_port     = r.dest;
        candidate_ovc = r.cand;
        granted_ovc   = r.gnt_ovc;
    endtask

    // watchdog on the whole run
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        noc_geom_pkg::pv_vec_t      z;
        noc_geom_pkg::pv_vec_t      a;
        noc_geom_pkg::pv_vec_t      b;
        noc_geom_pkg::pv_vec_t      o;
        noc_geom_pkg::pv_vec_t      all_free;
        noc_geom_pkg::pv_vec_t      o_busy;
        noc_geom_pkg::vc_mask_arr_t zm;
        noc_geom_pkg::vc_mask_arr_t ca;
        noc_geom_pkg::vc_mask_arr_t cb;
        noc_geom_pkg::vc_mask_arr_t cb0;

        row_count   = 0;
        error_count = 0;
        check_count = 0;
        apply_row('0);

        // west vc0 (a) and north vc0 (b) both head east; dest bit 1 is east for both
        east_dest    = '0;
        east_dest[4] = 4'b0010;
        east_dest[6] = 4'b0010;
        z        = '0;
        a        = one_bit(6);
        b        = one_bit(4);
        o        = one_bit(3);
        all_free = '1;
        o_busy   = ~o;
        zm       = '0;
        ca       = vc_at(6, 2'b10);
        cb       = vc_at(4, 2'b10);
        cb0      = vc_at(4, 2'b01);

        // req, tail, ovc_gnt, sw_gnt, cred, cand, gnt_ovc | masked, assigned, avail,
        // not_full, credit_out
        add_row(z, z, z, z, z, zm, zm, zm, z, all_free, z, z);
        add_row(a, z, z, z, z, ca, zm, ca, z, all_free, z, z);
        add_row(a | b, z, b, z, z, ca | cb, cb, ca | cb, b, o_busy, b, z);
        // a blocked by busy east vc1, b blocked by its own assignment
        add_row(a | b, z, z, z, z, ca | cb0, zm, zm, b, o_busy, b, z);
        add_row(z, z, z, b, z, zm, zm, zm, b, o_busy, b, b);
        add_row(z, z, z, b, z, zm, zm, zm, b, o_busy, b, b);
        add_row(z, z, z, b, z, zm, zm, zm, b, o_busy, b, b);
        add_row(z, z, z, b, z, zm, zm, zm, b, o_busy, z, b);
        add_row(z, z, z, z, z, zm, zm, zm, b, o_busy, z, z);
        add_row(z, z, z, z, o, zm, zm, zm, b, o_busy, b, z);
        // tail and a new grant together, the release wins
        add_row(z, b, b, b, z, zm, cb, zm, z, all_free, z, b);
        add_row(a, z, a, z, z, ca, ca, ca, a, o_busy, z, z);
        add_row(z, z, z, z, o, zm, zm, zm, a, o_busy, a, z);
        add_row(z, a, z, a, z, zm, zm, zm, z, all_free, z, a);
        add_row(z, z, z, z, o, zm, zm, zm, z, all_free, z, z);
        add_row(z, z, z, z, z, zm, zm, zm, z, all_free, z, z);

        if (row_count != NUM_ROWS) begin
            error_count++;
            $display("stimulus table holds %0d rows but %0d were expected",
                     row_count, NUM_ROWS);
        end

        wait (reset == 1'b0);
        @(posedge clk);
        #1;
        for (int k = 0; k < NUM_ROWS; k++) begin
            apply_row(rows[k]);
            #40;
            compare(k, "masked_ovc_request", masked_ovc_request, rows[k].exp_masked);
            @(posedge clk);
            #1;
            compare(k, "ovc_is_assigned", ovc_is_assigned, rows[k].exp_assigned);
            compare(k, "ovc_available", ovc_available, rows[k].exp_avail);
            compare(k, "assigned_ovc_not_full", assigned_ovc_not_full, rows[k].exp_not_full);
            compare(k, "credit_out", credit_out, rows[k].exp_credit);
        end

        $display("tb_inout_ports: %0d rows, %0d checks, %0d errors",
                 NUM_ROWS, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
